// File: rtl/prbs_link_pkg.sv
package prbs_link_pkg;

   //////////////////////////////////////////////////////////////////////
   // PRBS polynomial
   //////////////////////////////////////////////////////////////////////

   // x^7 + x^6 + 1
   localparam int PRBS_ORDER = 7;
   // second tap of the polynomial
   localparam int PRBS_TAP = 6;
   // generator state loaded under reset
   localparam logic [PRBS_ORDER-1:0] PRBS_SEED = '1;

   //////////////////////////////////////////////////////////////////////
   // default link geometry
   //////////////////////////////////////////////////////////////////////

   // one transceiver word per clock
   localparam int DEF_WORD_W = 64;
   // receive lanes under test
   localparam int DEF_NUM_LANES = 8;
   // clean words in a row before lock
   localparam int DEF_LOCK_WORDS = 4;

   // per word error count, up to 127
   localparam int WERR_W = 7;
   // running bit error total
   localparam int TOT_W = 24;
   // readout start offset
   localparam int INIT_W = 8;

   // result of one lane checker, 32 bits
   typedef struct packed {
      logic              aligned;
      logic [WERR_W-1:0] word_errors;
      logic [TOT_W-1:0]  total_errors;
   } lane_status_t;

   // channel select width, never below one bit
   function automatic int sel_w(input int lanes);
      if (lanes > 1)
      begin
         return $clog2(lanes);
      end
      return 1;
   endfunction

endpackage

// File: rtl/prbs7_gen.sv
`timescale 1ns/1ps

module prbs7_gen #(
   parameter int WORD_W = prbs_link_pkg::DEF_WORD_W
) (
   input  logic              clk_i,
   input  logic              rst_i,
   output logic [WORD_W-1:0] word_o
);
   import prbs_link_pkg::*;

   // next stream bits still to be sent
   // bit 0 is the oldest one, so it leaves first
   logic [PRBS_ORDER-1:0] state_q;
   logic [PRBS_ORDER-1:0] state_d;
   logic [WORD_W-1:0]     word_d;

   //////////////////////////////////////////////////////////////////////
   // unrolled LFSR steps
   //////////////////////////////////////////////////////////////////////

   // one stream bit per step, lsb of the word first
   always_comb
   begin
      state_d = state_q;
      word_d  = '0;
      for (int i = 0; i < WORD_W; i++)
      begin
         // emit the oldest pending bit
         word_d[i] = state_d[0];
         // new bit is bit n-7 xor bit n-6
         state_d = {state_d[0] ^ state_d[PRBS_ORDER-PRBS_TAP],
                    state_d[PRBS_ORDER-1:1]};
      end
   end

   //////////////////////////////////////////////////////////////////////
   // state and output registers
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk_i)
   begin
      if (rst_i)
      begin
         // seed comes out as the first seven bits
         state_q <= PRBS_SEED;
         word_o  <= '0;
      end
      else
      begin
         state_q <= state_d;
         word_o  <= word_d;
      end
   end

endmodule

// File: rtl/lane_checker.sv
`timescale 1ns/1ps

module lane_checker #(
   parameter int WORD_W     = prbs_link_pkg::DEF_WORD_W,
   parameter int LOCK_WORDS = prbs_link_pkg::DEF_LOCK_WORDS
) (
   input  logic                        clk_i,
   input  logic                        rst_i,
   input  logic [WORD_W-1:0]           rx_word_i,
   output prbs_link_pkg::lane_status_t status_o
);
   import prbs_link_pkg::*;

   // run counter reaches LOCK_WORDS and stays there
   localparam int RUN_W = $clog2(LOCK_WORDS + 1);

   // previous receive word and its valid flag
   logic [WORD_W-1:0]   prev_q;
   logic                prev_vld_q;

   // received history, previous word in the low half
   logic [2*WORD_W-1:0] hist;
   logic [WORD_W-1:0]   exp_bits;
   logic [WORD_W-1:0]   err_bits;
   logic [WERR_W-1:0]   werr_d;

   // lock tracking
   logic [RUN_W-1:0]    run_q;
   logic [RUN_W-1:0]    run_d;
   logic                aligned_d;

   // saturating total
   logic [WERR_W-1:0]   werr_add;
   logic [TOT_W:0]      tot_sum;
   logic [TOT_W-1:0]    tot_d;

   lane_status_t        status_q;

   //////////////////////////////////////////////////////////////////////
   // self-synchronizing check
   //////////////////////////////////////////////////////////////////////

   assign hist = {rx_word_i, prev_q};

   // expected bit from the received stream itself
   // low bits reach back into the previous word
   always_comb
   begin
      for (int n = 0; n < WORD_W; n++)
      begin
         exp_bits[n] = hist[WORD_W+n-PRBS_ORDER] ^ hist[WORD_W+n-PRBS_TAP];
      end
   end

   assign err_bits = rx_word_i ^ exp_bits;

   // count mismatching bits
   always_comb
   begin
      werr_d = '0;
      for (int n = 0; n < WORD_W; n++)
      begin
         werr_d = werr_d + WERR_W'(err_bits[n]);
      end
      // no history for the first word after reset
      if (!prev_vld_q)
      begin
         werr_d = '0;
      end
   end

   //////////////////////////////////////////////////////////////////////
   // lock and error total
   //////////////////////////////////////////////////////////////////////

   always_comb
   begin
      run_d     = run_q;
      aligned_d = status_q.aligned;
      if (werr_d != '0)
      begin
         // any error drops lock and restarts the run
         run_d     = '0;
         aligned_d = 1'b0;
      end
      else if (prev_vld_q)
      begin
         if (run_q < RUN_W'(LOCK_WORDS))
         begin
            run_d = run_q + 1'b1;
         end
         if (run_d == RUN_W'(LOCK_WORDS))
         begin
            aligned_d = 1'b1;
         end
      end
   end

   // errors only count while locked on arrival
   assign werr_add = status_q.aligned ? werr_d : '0;
   assign tot_sum  = {1'b0, status_q.total_errors} + (TOT_W+1)'(werr_add);
   // clamp at all ones
   assign tot_d    = tot_sum[TOT_W] ? '1 : tot_sum[TOT_W-1:0];

   //////////////////////////////////////////////////////////////////////
   // registers
   //////////////////////////////////////////////////////////////////////

   // history word
   always_ff @(posedge clk_i)
   begin
      prev_q <= rx_word_i;
   end

   always_ff @(posedge clk_i)
   begin
      if (rst_i)
      begin
         prev_vld_q <= 1'b0;
         run_q      <= '0;
         status_q   <= '0;
      end
      else
      begin
         prev_vld_q            <= 1'b1;
         run_q                 <= run_d;
         status_q.aligned      <= aligned_d;
         status_q.word_errors  <= werr_d;
         status_q.total_errors <= tot_d;
      end
   end

   assign status_o = status_q;

endmodule

// File: rtl/error_readout.sv
`timescale 1ns/1ps

module error_readout #(
   parameter int NUM_LANES = prbs_link_pkg::DEF_NUM_LANES
) (
   input  logic                                       clk_i,
   input  logic                                       rst_i,
   input  prbs_link_pkg::lane_status_t                lanes_i [NUM_LANES],
   input  logic [prbs_link_pkg::sel_w(NUM_LANES)-1:0] chan_sel_i,
   input  logic [prbs_link_pkg::INIT_W-1:0]           err_init_i,
   output logic [prbs_link_pkg::TOT_W-1:0]            status_o,
   output logic                                       err_flag_o,
   output logic [NUM_LANES-1:0]                       aligned_o
);
   import prbs_link_pkg::*;

   logic [TOT_W-1:0]     sel_total;
   logic [TOT_W:0]       sum;
   logic [TOT_W-1:0]     status_d;
   logic                 err_any;
   logic [NUM_LANES-1:0] aligned_d;

   //////////////////////////////////////////////////////////////////////
   // lane select and merge
   //////////////////////////////////////////////////////////////////////

   always_comb
   begin
      sel_total = '0;
      err_any   = 1'b0;
      for (int k = 0; k < NUM_LANES; k++)
      begin
         // selected channel total
         if (int'(chan_sel_i) == k)
         begin
            sel_total = lanes_i[k].total_errors;
         end
         // any lane with errors this word
         err_any      = err_any | (lanes_i[k].word_errors != '0);
         aligned_d[k] = lanes_i[k].aligned;
      end
   end

   // offset added on top, clamped at all ones
   assign sum      = {1'b0, sel_total} + (TOT_W+1)'(err_init_i);
   assign status_d = sum[TOT_W] ? '1 : sum[TOT_W-1:0];

   //////////////////////////////////////////////////////////////////////
   // output registers
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk_i)
   begin
      if (rst_i)
      begin
         status_o   <= '0;
         err_flag_o <= 1'b0;
         aligned_o  <= '0;
      end
      else
      begin
         status_o   <= status_d;
         err_flag_o <= err_any;
         aligned_o  <= aligned_d;
      end
   end

endmodule

// File: rtl/prbs_link_top.sv
`timescale 1ns/1ps

module prbs_link_top #(
   parameter int WORD_W     = prbs_link_pkg::DEF_WORD_W,
   parameter int NUM_LANES  = prbs_link_pkg::DEF_NUM_LANES,
   parameter int LOCK_WORDS = prbs_link_pkg::DEF_LOCK_WORDS
) (
   input  logic                                       clk_i,
   input  logic                                       rst_i,
   // one receive word per lane, lane k in slice k
   input  logic [NUM_LANES-1:0][WORD_W-1:0]           rx_words_i,
   input  logic [prbs_link_pkg::sel_w(NUM_LANES)-1:0] chan_sel_i,
   input  logic [prbs_link_pkg::INIT_W-1:0]           err_init_i,
   output logic [WORD_W-1:0]                          tx_word_o,
   output logic [prbs_link_pkg::TOT_W-1:0]            status_o,
   output logic                                       err_flag_o,
   output logic [NUM_LANES-1:0]                       aligned_o
);
   import prbs_link_pkg::*;

   // checker results into the readout
   lane_status_t lane_status [NUM_LANES];

   //////////////////////////////////////////////////////////////////////
   // transmit side
   //////////////////////////////////////////////////////////////////////

   prbs7_gen #(
      .WORD_W (WORD_W)
   ) u_gen (
      .clk_i  (clk_i),
      .rst_i  (rst_i),
      .word_o (tx_word_o)
   );

   //////////////////////////////////////////////////////////////////////
   // receive lanes
   //////////////////////////////////////////////////////////////////////

   // one checker per lane, fed straight from the ports
   for (genvar k = 0; k < NUM_LANES; k++)
   begin : g_lane
      lane_checker #(
         .WORD_W     (WORD_W),
         .LOCK_WORDS (LOCK_WORDS)
      ) u_chk (
         .clk_i     (clk_i),
         .rst_i     (rst_i),
         .rx_word_i (rx_words_i[k]),
         .status_o  (lane_status[k])
      );
   end

   // status readout
   error_readout #(
      .NUM_LANES (NUM_LANES)
   ) u_readout (
      .clk_i      (clk_i),
      .rst_i      (rst_i),
      .lanes_i    (lane_status),
      .chan_sel_i (chan_sel_i),
      .err_init_i (err_init_i),
      .status_o   (status_o),
      .err_flag_o (err_flag_o),
      .aligned_o  (aligned_o)
   );

endmodule

// File: tests/tb_prbs_model.svh
`ifndef TB_PRBS_MODEL_SVH
`define TB_PRBS_MODEL_SVH

//////////////////////////////////////////////////////////////////////
// reference PRBS7 stream
//////////////////////////////////////////////////////////////////////

// next word of the stream, earliest bit in bit 0
task automatic gen_word(output logic [WORD_W-1:0] w);
   logic b;
   for (int i = 0; i < WORD_W; i++)
   begin
      // seed bits leave first
      if (g_count < PRBS_ORDER)
      begin
         b = PRBS_SEED[g_count[2:0]];
         g_count++;
      end
      else
      begin
         b = g_hist[0] ^ g_hist[PRBS_ORDER-PRBS_TAP];
      end
      w[i] = b;
      // g_hist[0] holds bit n-7 of the next step
      g_hist = {b, g_hist[PRBS_ORDER-1:1]};
   end
endtask

// walk the received stream bit by bit
function automatic int count_stream_errors(input logic [WORD_W-1:0] prev,
                                           input logic [WORD_W-1:0] cur);
   logic [PRBS_ORDER-1:0] h;
   logic                  exp_bit;
   int                    errs;
   // last seven bits of the previous word
   h    = prev[WORD_W-1 -: PRBS_ORDER];
   errs = 0;
   for (int n = 0; n < WORD_W; n++)
   begin
      exp_bit = h[0] ^ h[PRBS_ORDER-PRBS_TAP];
      if (cur[n] != exp_bit)
      begin
         errs++;
      end
      h = {cur[n], h[PRBS_ORDER-1:1]};
   end
   return errs;
endfunction

// clamps at the top of the counter
function automatic logic [TOT_W-1:0] sat_add(input logic [TOT_W-1:0] a, input int b);
   longint s;
   s = longint'(a) + longint'(b);
   if (s > TOT_MAX)
   begin
      return '1;
   end
   return TOT_W'(s);
endfunction

//////////////////////////////////////////////////////////////////////
// lane and readout model
//////////////////////////////////////////////////////////////////////

task automatic lane_update(input int k, input logic [WORD_W-1:0] word);
   int errs;
   int add;
   // first word after reset has no history
   errs = m_vld[k] ? count_stream_errors(m_prev[k], word) : 0;
   // lock state on arrival decides the count
   add  = m_aligned[k] ? errs : 0;
   if (errs != 0)
   begin
      m_run[k]     = 0;
      m_aligned[k] = 1'b0;
   end
   else if (m_vld[k])
   begin
      if (m_run[k] < LOCK_WORDS)
      begin
         m_run[k]++;
      end
      if (m_run[k] == LOCK_WORDS)
      begin
         m_aligned[k] = 1'b1;
      end
   end
   m_total[k] = sat_add(m_total[k], add);
   m_werr[k]  = errs;
   m_vld[k]   = 1'b1;
   m_prev[k]  = word;
endtask

// one clock edge, from the inputs that were driven before it
task automatic model_edge();
   logic flag;
   if (rst_i)
   begin
      g_hist      = '0;
      g_count     = 0;
      exp_tx      = '0;
      exp_status  = '0;
      exp_flag    = 1'b0;
      exp_aligned = '0;
      m_vld       = '0;
      m_aligned   = '0;
      for (int k = 0; k < NUM_LANES; k++)
      begin
         m_run[k]   = 0;
         m_werr[k]  = 0;
         m_total[k] = '0;
         // history word has no reset
         m_prev[k]  = rx_words_i[k];
      end
      chk_en = 1'b1;
   end
   else
   begin
      // readout sees the lane state from before this edge
      flag = 1'b0;
      for (int k = 0; k < NUM_LANES; k++)
      begin
         flag = flag | (m_werr[k] != 0);
      end
      exp_flag    = flag;
      exp_aligned = m_aligned;
      exp_status  = sat_add(m_total[chan_sel_i], int'(err_init_i));
      for (int k = 0; k < NUM_LANES; k++)
      begin
         lane_update(k, rx_words_i[k]);
      end
      gen_word(exp_tx);
   end
endtask

`endif

// File: tests/tb_prbs_link.sv
`timescale 1ns/1ps

module tb_prbs_link;
   import prbs_link_pkg::*;

   localparam int WORD_W     = DEF_WORD_W;
   localparam int NUM_LANES  = DEF_NUM_LANES;
   localparam int LOCK_WORDS = DEF_LOCK_WORDS;
   localparam int SEL_W      = $clog2(NUM_LANES);
   localparam int POS_W      = $clog2(WORD_W);
   localparam longint TOT_MAX = (longint'(1) << TOT_W) - 1;

   localparam int CLK_PERIOD = 10;
   localparam int RST_CYCLES = 8;
   // test lengths in words
   localparam int N_STREAM    = 16;
   localparam int LOCK_LIMIT  = 20;
   localparam int N_CLEAN     = 24;
   localparam int N_FLIP_ITER = 40;
   localparam int N_RELOCK    = 8;
   localparam int N_SEL       = 64;
   localparam int SETTLE      = 3;
   localparam int WATCHDOG_CYCLES = RST_CYCLES + N_STREAM + LOCK_LIMIT + N_CLEAN
                                  + N_FLIP_ITER * 8 + N_RELOCK * (2 * LOCK_LIMIT + 3)
                                  + N_SEL + 5 * SETTLE + 100;

   // DUT ports
   logic                              clk_i;
   logic                              rst_i;
   logic [NUM_LANES-1:0][WORD_W-1:0]  rx_words_i;
   logic [SEL_W-1:0]                  chan_sel_i;
   logic [INIT_W-1:0]                 err_init_i;
   logic [WORD_W-1:0]                 tx_word_o;
   logic [TOT_W-1:0]                  status_o;
   logic                              err_flag_o;
   logic [NUM_LANES-1:0]              aligned_o;

   // model state
   logic [PRBS_ORDER-1:0] g_hist;
   int                    g_count;
   logic [WORD_W-1:0]     m_prev [NUM_LANES];
   logic [NUM_LANES-1:0]  m_vld;
   int                    m_run [NUM_LANES];
   logic [NUM_LANES-1:0]  m_aligned;
   int                    m_werr [NUM_LANES];
   logic [TOT_W-1:0]      m_total [NUM_LANES];

   // expected outputs after the last edge
   logic [WORD_W-1:0]     exp_tx;
   logic [TOT_W-1:0]      exp_status;
   logic                  exp_flag;
   logic [NUM_LANES-1:0]  exp_aligned;
   logic                  chk_en;

   // values for the next driven word
   logic                  cur_rst;
   logic [SEL_W-1:0]      cur_sel;
   logic [INIT_W-1:0]     cur_init;

   int err_count;
   int test_err_start;
   int tests_run;
   int tests_bad;

   `include "tb_prbs_model.svh"

   prbs_link_top #(
      .WORD_W     (WORD_W),
      .NUM_LANES  (NUM_LANES),
      .LOCK_WORDS (LOCK_WORDS)
   ) u_dut (
      .clk_i      (clk_i),
      .rst_i      (rst_i),
      .rx_words_i (rx_words_i),
      .chan_sel_i (chan_sel_i),
      .err_init_i (err_init_i),
      .tx_word_o  (tx_word_o),
      .status_o   (status_o),
      .err_flag_o (err_flag_o),
      .aligned_o  (aligned_o)
   );

   initial
   begin
      clk_i = 1'b0;
      forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
   end

   //////////////////////////////////////////////////////////////////////
   // checks
   //////////////////////////////////////////////////////////////////////

   task automatic report_mismatch(input string msg);
      $display("MISMATCH at %0t: %s", $time, msg);
      err_count++;
   endtask

   // outputs and model both settle away from the rising edge
   a_tx_word: assert property (@(posedge clk_i) chk_en |-> (tx_word_o == exp_tx))
      else report_mismatch($sformatf("tx_word_o %h, expected %h", $sampled(tx_word_o), exp_tx));
   a_status: assert property (@(posedge clk_i) chk_en |-> (status_o == exp_status))
      else report_mismatch($sformatf("status_o %0d, expected %0d", $sampled(status_o),
                                     exp_status));
   a_err_flag: assert property (@(posedge clk_i) chk_en |-> (err_flag_o == exp_flag))
      else report_mismatch($sformatf("err_flag_o %b, expected %b", $sampled(err_flag_o),
                                     exp_flag));
   a_aligned: assert property (@(posedge clk_i) chk_en |-> (aligned_o == exp_aligned))
      else report_mismatch($sformatf("aligned_o %b, expected %b", $sampled(aligned_o),
                                     exp_aligned));

   //////////////////////////////////////////////////////////////////////
   // stimulus
   //////////////////////////////////////////////////////////////////////

   // loopback of tx into all lanes, one lane optionally corrupted
   task automatic step(input int flip_lane, input logic [WORD_W-1:0] flip_mask);
      @(negedge clk_i);
      model_edge();
      for (int k = 0; k < NUM_LANES; k++)
      begin
         rx_words_i[k] = (k == flip_lane) ? (tx_word_o ^ flip_mask) : tx_word_o;
      end
      rst_i      = cur_rst;
      chan_sel_i = cur_sel;
      err_init_i = cur_init;
   endtask

   function automatic logic [WORD_W-1:0] rand_mask(input int nbits);
      logic [WORD_W-1:0] m;
      logic [POS_W-1:0]  pos;
      m = '0;
      for (int j = 0; j < nbits; j++)
      begin
         pos    = POS_W'($urandom);
         m[pos] = 1'b1;
      end
      return m;
   endfunction

   // clean words until every lane in mask shows lock
   task automatic wait_aligned(input logic [NUM_LANES-1:0] mask);
      int n;
      n = 0;
      while (((aligned_o & mask) != mask) && (n < LOCK_LIMIT))
      begin
         step(-1, '0);
         n++;
      end
      if ((aligned_o & mask) != mask)
      begin
         $display("lanes %b did not lock within %0d words", mask, LOCK_LIMIT);
         err_count++;
      end
   endtask

   task automatic finish_test(input string name);
      int errs;
      // let the 2-cycle pipeline drain into this test
      for (int i = 0; i < SETTLE; i++)
      begin
         step(-1, '0);
      end
      errs = err_count - test_err_start;
      tests_run++;
      if (errs != 0)
      begin
         tests_bad++;
         $display("test %0s: %0d errors", name, errs);
      end
      else
      begin
         $display("test %0s: clean", name);
      end
   endtask

   //////////////////////////////////////////////////////////////////////
   // tests
   //////////////////////////////////////////////////////////////////////

   task automatic run_stream_test();
      test_err_start = err_count;
      // first reset edge comes from the initial values
      for (int i = 1; i < RST_CYCLES; i++)
      begin
         step(-1, '0);
      end
      cur_rst = 1'b0;
      for (int i = 0; i < N_STREAM; i++)
      begin
         step(-1, '0);
      end
      finish_test("reset_and_stream");
   endtask

   task automatic run_lock_test();
      test_err_start = err_count;
      wait_aligned('1);
      for (int i = 0; i < N_CLEAN; i++)
      begin
         cur_sel = cur_sel + 1'b1;
         step(-1, '0);
      end
      finish_test("loopback_lock");
   endtask

   task automatic run_flip_test();
      int lane;
      int nwords;
      int gap;
      test_err_start = err_count;
      for (int it = 0; it < N_FLIP_ITER; it++)
      begin
         lane   = int'($urandom % NUM_LANES);
         nwords = 1 + int'($urandom % 2);
         for (int w = 0; w < nwords; w++)
         begin
            step(lane, rand_mask(1 + int'($urandom % 3)));
         end
         // short gaps leave the lane unlocked on the next flip
         gap = 1 + int'($urandom % 6);
         for (int g = 0; g < gap; g++)
         begin
            cur_sel = cur_sel + 1'b1;
            step(-1, '0);
         end
      end
      finish_test("random_flips");
   endtask

   task automatic run_relock_test();
      int lane;
      test_err_start = err_count;
      for (int it = 0; it < N_RELOCK; it++)
      begin
         wait_aligned('1);
         lane = int'($urandom % NUM_LANES);
         step(lane, rand_mask(1));
         step(-1, '0);
         step(-1, '0);
         if (aligned_o[lane])
         begin
            $display("lane %0d kept its lock after a flipped word", lane);
            err_count++;
         end
         wait_aligned(NUM_LANES'(1) << lane);
      end
      finish_test("relock");
   endtask

   task automatic run_readout_test();
      test_err_start = err_count;
      for (int i = 0; i < N_SEL; i++)
      begin
         cur_sel  = SEL_W'($urandom);
         cur_init = INIT_W'($urandom);
         if ((i % 8) == 7)
         begin
            step(int'($urandom % NUM_LANES), rand_mask(1 + int'($urandom % 2)));
         end
         else
         begin
            step(-1, '0);
         end
      end
      finish_test("readout_select");
   endtask

   initial
   begin
      void'($urandom(32'h247aa747));
      err_count      = 0;
      test_err_start = 0;
      tests_run      = 0;
      tests_bad      = 0;
      chk_en         = 1'b0;
      cur_rst        = 1'b1;
      cur_sel        = '0;
      cur_init       = '0;
      rst_i          = 1'b1;
      rx_words_i     = '0;
      chan_sel_i     = '0;
      err_init_i     = '0;

      run_stream_test();
      run_lock_test();
      run_flip_test();
      run_relock_test();
      run_readout_test();

      $display("%0d tests, %0d failed, %0d errors", tests_run, tests_bad, err_count);
      if ((err_count == 0) && (tests_bad == 0))
      begin
         $display("Everything OK");
      end
      else
      begin
         $display("Something failed");
      end
      $finish;
   end

   // upper bound from the summed test lengths
   initial
   begin
      #(WATCHDOG_CYCLES * CLK_PERIOD);
      $display("timeout: run did not end within %0d clock cycles", WATCHDOG_CYCLES);
      $display("Something failed");
      $finish;
   end

endmodule

// File: Makefile
VERILATOR  ?= verilator
FILELIST   := all.f
TOP        := tb_prbs_link
LINT_FLAGS := --lint-only -Wall --assert --timing
SIM_FLAGS  := --binary --assert --timing -Mdir obj_dir
PASS_MSG   := Everything OK
BIN        := obj_dir/V$(TOP)

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP)

# status comes from grep, so a missing pass line fails the target
sim: build
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf obj_dir

// File: all.f
+incdir+tests
rtl/prbs_link_pkg.sv
rtl/prbs7_gen.sv
rtl/lane_checker.sv
rtl/error_readout.sv
rtl/prbs_link_top.sv
tests/tb_prbs_link.sv
